// File: axi2iob_top.f
logic/axi2iob_pkg.sv
logic/lite_wr_if.sv
logic/lite_rd_if.sv
logic/axi_wr_burst.sv
logic/axi_rd_burst.sv
logic/iob_bus_bridge.sv
logic/axi2iob_top.sv
sim/tb_mem_model.sv
sim/axi2iob_tb.sv

// File: logic/axi2iob_pkg.sv
// Shared widths, field types and burst arithmetic for the AXI4 to IOb adapter.
// Imported by every RTL module and interface of the design.
package axi2iob_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int ID_W   = 8;
   localparam int LEN_W  = 8;
   localparam int SIZE_W = 3;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [ID_W-1:0]   id_t;
   // beats in the burst minus one
   typedef logic [LEN_W-1:0]  len_t;
   // log2 of the bytes per beat
   typedef logic [SIZE_W-1:0] size_t;

   // the read sequencer never enters RESP
   typedef enum logic [1:0] {
      IDLE,
      DATA,
      RESP
   } burst_state_t;

   // address increment between two beats of an incrementing burst
   function automatic addr_t beat_step(size_t size);
      addr_t step;
      step = addr_t'(1) << size;
      return step;
   endfunction

endpackage

// File: logic/axi2iob_top.sv
// AXI4 subordinate to IOb manager adapter. Plain AXI4 ports on one side and
// the IOb port on the other; the burst sequencers meet at the bus bridge.
`timescale 1ns/1ps

module axi2iob_top (
   input  logic               clk_i,
   input  logic               arst_i,
   input  axi2iob_pkg::id_t   awid_i,
   input  axi2iob_pkg::addr_t awaddr_i,
   input  axi2iob_pkg::len_t  awlen_i,
   input  axi2iob_pkg::size_t awsize_i,
   input  logic               awvalid_i,
   output logic               awready_o,
   input  axi2iob_pkg::data_t wdata_i,
   input  axi2iob_pkg::strb_t wstrb_i,
   // burst end comes from the length, wlast is not looked at
   input  logic               wlast_i,
   input  logic               wvalid_i,
   output logic               wready_o,
   output axi2iob_pkg::id_t   bid_o,
   output logic               bvalid_o,
   input  logic               bready_i,
   input  axi2iob_pkg::id_t   arid_i,
   input  axi2iob_pkg::addr_t araddr_i,
   input  axi2iob_pkg::len_t  arlen_i,
   input  axi2iob_pkg::size_t arsize_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   output axi2iob_pkg::id_t   rid_o,
   output axi2iob_pkg::data_t rdata_o,
   output logic               rlast_o,
   output logic               rvalid_o,
   input  logic               rready_i,
   output logic               iob_valid_o,
   output axi2iob_pkg::addr_t iob_addr_o,
   output axi2iob_pkg::data_t iob_wdata_o,
   output axi2iob_pkg::strb_t iob_wstrb_o,
   input  logic               iob_ready_i,
   input  logic               iob_rvalid_i,
   input  axi2iob_pkg::data_t iob_rdata_i
);

   lite_wr_if wr_if ();
   lite_rd_if rd_if ();

   axi_wr_burst u_wr_burst (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .awid_i   (awid_i),
      .awaddr_i (awaddr_i),
      .awlen_i  (awlen_i),
      .awsize_i (awsize_i),
      .awvalid_i(awvalid_i),
      .awready_o(awready_o),
      .wdata_i  (wdata_i),
      .wstrb_i  (wstrb_i),
      .wvalid_i (wvalid_i),
      .wready_o (wready_o),
      .bid_o    (bid_o),
      .bvalid_o (bvalid_o),
      .bready_i (bready_i),
      .lite     (wr_if.manager)
   );

   axi_rd_burst u_rd_burst (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .arid_i   (arid_i),
      .araddr_i (araddr_i),
      .arlen_i  (arlen_i),
      .arsize_i (arsize_i),
      .arvalid_i(arvalid_i),
      .arready_o(arready_o),
      .rid_o    (rid_o),
      .rdata_o  (rdata_o),
      .rlast_o  (rlast_o),
      .rvalid_o (rvalid_o),
      .rready_i (rready_i),
      .lite     (rd_if.manager)
   );

   iob_bus_bridge u_bridge (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .wr          (wr_if.subordinate),
      .rd          (rd_if.subordinate),
      .iob_valid_o (iob_valid_o),
      .iob_addr_o  (iob_addr_o),
      .iob_wdata_o (iob_wdata_o),
      .iob_wstrb_o (iob_wstrb_o),
      .iob_ready_i (iob_ready_i),
      .iob_rvalid_i(iob_rvalid_i),
      .iob_rdata_i (iob_rdata_i)
   );

endmodule

// File: logic/axi_rd_burst.sv
// Read burst sequencer. Issues one single-beat read per AXI4 beat and returns
// each word with the burst ID, marking the final word with rlast.
`timescale 1ns/1ps

module axi_rd_burst (
   input  logic               clk_i,
   input  logic               arst_i,
   input  axi2iob_pkg::id_t   arid_i,
   input  axi2iob_pkg::addr_t araddr_i,
   input  axi2iob_pkg::len_t  arlen_i,
   input  axi2iob_pkg::size_t arsize_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   output axi2iob_pkg::id_t   rid_o,
   output axi2iob_pkg::data_t rdata_o,
   output logic               rlast_o,
   output logic               rvalid_o,
   input  logic               rready_i,
   lite_rd_if.manager         lite
);
   import axi2iob_pkg::*;

   burst_state_t state;
   logic  arready_q, rvalid_q, rlast_q;
   logic  arvalid_q, rready_q;
   logic  ar_hs, r_hs;
   id_t   id_q, rid_q;
   addr_t addr_q;
   len_t  len_q;
   size_t size_q;
   data_t rdata_q;

   assign ar_hs = arready_q && arvalid_i;
   assign r_hs  = rready_q && lite.rvalid;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state     <= IDLE;
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rlast_q   <= 1'b0;
         arvalid_q <= 1'b0;
         rready_q  <= 1'b0;
      end else begin
         arready_q <= 1'b0;
         rready_q  <= 1'b0;
         if (lite.arvalid && lite.arready) arvalid_q <= 1'b0;
         if (rvalid_q && rready_i) begin
            rvalid_q <= 1'b0;
            rlast_q  <= 1'b0;
         end
         case (state)
            IDLE: begin
               arready_q <= !arvalid_q;
               if (ar_hs) begin
                  arready_q <= 1'b0;
                  arvalid_q <= 1'b1;
                  state     <= DATA;
               end
            end
            DATA: begin
               // take the next word only once the previous one has left rvalid_o
               rready_q <= !rvalid_q && !arvalid_q;
               if (r_hs) begin
                  rready_q <= 1'b0;
                  rvalid_q <= 1'b1;
                  rlast_q  <= (len_q == '0);
                  if (len_q == '0) begin
                     arready_q <= !arvalid_q;
                     state     <= IDLE;
                  end else begin
                     arvalid_q <= 1'b1;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         id_q   <= arid_i;
         addr_q <= araddr_i;
         len_q  <= arlen_i;
         size_q <= arsize_i;
      end else if (r_hs && len_q != '0) begin
         addr_q <= addr_q + beat_step(size_q);
         len_q  <= len_q - 1'b1;
      end
      if (r_hs) begin
         rid_q   <= id_q;
         rdata_q <= lite.rdata;
      end
   end

   assign arready_o    = arready_q;
   assign rvalid_o     = rvalid_q;
   assign rlast_o      = rlast_q;
   assign rid_o        = rid_q;
   assign rdata_o      = rdata_q;
   assign lite.araddr  = addr_q;
   assign lite.arvalid = arvalid_q;
   assign lite.rready  = rready_q;

   a_rdata_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      rvalid_o && !rready_i |=> $stable(rdata_o))
      else $error("rdata_o changed while stalled");

   a_rlast_valid: assert property (@(posedge clk_i) disable iff (arst_i)
      rlast_o |-> rvalid_o)
      else $error("rlast_o without rvalid_o");

endmodule

// File: logic/axi_wr_burst.sv
// Write burst sequencer. Splits each AXI4 write burst into single-beat writes
// and answers the whole burst with one write response carrying its ID.
`timescale 1ns/1ps

module axi_wr_burst (
   input  logic               clk_i,
   input  logic               arst_i,
   input  axi2iob_pkg::id_t   awid_i,
   input  axi2iob_pkg::addr_t awaddr_i,
   input  axi2iob_pkg::len_t  awlen_i,
   input  axi2iob_pkg::size_t awsize_i,
   input  logic               awvalid_i,
   output logic               awready_o,
   input  axi2iob_pkg::data_t wdata_i,
   input  axi2iob_pkg::strb_t wstrb_i,
   input  logic               wvalid_i,
   output logic               wready_o,
   output axi2iob_pkg::id_t   bid_o,
   output logic               bvalid_o,
   input  logic               bready_i,
   lite_wr_if.manager         lite
);
   import axi2iob_pkg::*;

   burst_state_t state;
   logic  awready_q, wready_q, bvalid_q;
   logic  awvalid_q, wvalid_q, bready_q;
   logic  aw_hs, w_hs, b_hs;
   id_t   id_q, bid_q;
   addr_t addr_q;
   len_t  len_q;
   size_t size_q;
   data_t wdata_q;
   strb_t wstrb_q;

   assign aw_hs = awready_q && awvalid_i;
   assign w_hs  = wready_q && wvalid_i;
   assign b_hs  = bready_q && lite.bvalid;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state     <= IDLE;
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         bvalid_q  <= 1'b0;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         bready_q  <= 1'b0;
      end else begin
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         bready_q  <= 1'b0;
         if (lite.awvalid && lite.awready) awvalid_q <= 1'b0;
         if (lite.wvalid && lite.wready) wvalid_q <= 1'b0;
         if (bvalid_q && bready_i) bvalid_q <= 1'b0;
         case (state)
            IDLE: begin
               awready_q <= !awvalid_q;
               if (aw_hs) begin
                  awready_q <= 1'b0;
                  awvalid_q <= 1'b1;
                  wready_q  <= !wvalid_q;
                  state     <= DATA;
               end
            end
            DATA: begin
               wready_q <= !wvalid_q;
               if (w_hs) begin
                  wready_q <= 1'b0;
                  wvalid_q <= 1'b1;
                  bready_q <= !bvalid_q;
                  state    <= RESP;
               end
            end
            RESP: begin
               // single response may not complete while the burst response waits
               bready_q <= !bvalid_q;
               if (b_hs) begin
                  bready_q <= 1'b0;
                  if (len_q != '0) begin
                     awvalid_q <= 1'b1;
                     wready_q  <= 1'b1;
                     state     <= DATA;
                  end else begin
                     bvalid_q  <= 1'b1;
                     awready_q <= !awvalid_q;
                     state     <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // burst context and beat payload
   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         id_q   <= awid_i;
         addr_q <= awaddr_i;
         len_q  <= awlen_i;
         size_q <= awsize_i;
      end else if (b_hs && len_q != '0) begin
         addr_q <= addr_q + beat_step(size_q);
         len_q  <= len_q - 1'b1;
      end
      if (w_hs) begin
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
      if (b_hs && len_q == '0) bid_q <= id_q;
   end

   assign awready_o    = awready_q;
   assign wready_o     = wready_q;
   assign bvalid_o     = bvalid_q;
   assign bid_o        = bid_q;
   assign lite.awaddr  = addr_q;
   assign lite.awvalid = awvalid_q;
   assign lite.wdata   = wdata_q;
   assign lite.wstrb   = wstrb_q;
   assign lite.wvalid  = wvalid_q;
   assign lite.bready  = bready_q;

   a_bvalid_held: assert property (@(posedge clk_i) disable iff (arst_i)
      bvalid_o && !bready_i |=> bvalid_o)
      else $error("bvalid_o dropped before bready_i");

   a_wready_in_data: assert property (@(posedge clk_i) disable iff (arst_i)
      wready_o |-> state == DATA)
      else $error("wready_o high outside the DATA state");

endmodule

// File: logic/iob_bus_bridge.sv
// Puts single-beat reads and writes onto one IOb manager port. Reads win over
// writes, and returned read data is held until the read sequencer takes it.
`timescale 1ns/1ps

module iob_bus_bridge (
   input  logic               clk_i,
   input  logic               arst_i,
   lite_wr_if.subordinate     wr,
   lite_rd_if.subordinate     rd,
   output logic               iob_valid_o,
   output axi2iob_pkg::addr_t iob_addr_o,
   output axi2iob_pkg::data_t iob_wdata_o,
   output axi2iob_pkg::strb_t iob_wstrb_o,
   input  logic               iob_ready_i,
   input  logic               iob_rvalid_i,
   input  axi2iob_pkg::data_t iob_rdata_i
);
   import axi2iob_pkg::*;

   addr_t awaddr_q;
   data_t rdata_q;
   logic  rvalid_q;
   logic  bvalid_q;
   logic  wr_en;

   // a write with no byte enabled completes without an IOb request
   assign wr_en = |wr.wstrb;

   assign wr.awready = iob_ready_i;
   // write waits while a read owns the port
   assign wr.wready  = iob_ready_i && !rd.arvalid;
   assign wr.bvalid  = bvalid_q;

   assign rd.arready = iob_ready_i;
   assign rd.rdata   = iob_rvalid_i ? iob_rdata_i : rdata_q;
   assign rd.rvalid  = iob_rvalid_i || rvalid_q;

   assign iob_valid_o = rd.arvalid || (wr.wvalid && wr_en);
   assign iob_addr_o  = rd.arvalid ? rd.araddr : (wr.awvalid ? wr.awaddr : awaddr_q);
   assign iob_wdata_o = wr.wdata;
   assign iob_wstrb_o = rd.arvalid ? '0 : wr.wstrb;

   // write address stays valid for the data beat that follows it
   always_ff @(posedge clk_i) begin
      if (wr.awvalid) awaddr_q <= wr.awaddr;
      if (iob_rvalid_i) rdata_q <= iob_rdata_i;
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rvalid_q <= 1'b0;
         bvalid_q <= 1'b0;
      end else begin
         if (rd.rvalid && rd.rready) begin
            rvalid_q <= 1'b0;
         end else if (iob_rvalid_i) begin
            rvalid_q <= 1'b1;
         end
         // single response one cycle after the write beat
         if (wr.wvalid && wr.wready) begin
            bvalid_q <= 1'b1;
         end else if (wr.bready) begin
            bvalid_q <= 1'b0;
         end
      end
   end

   a_iob_valid_held: assert property (@(posedge clk_i) disable iff (arst_i)
      iob_valid_o && !iob_ready_i |=> iob_valid_o)
      else $error("iob_valid_o dropped while iob_ready_i low");

endmodule

// File: logic/lite_rd_if.sv
// Single-beat read channel from the read burst sequencer to the bus bridge.
`timescale 1ns/1ps

interface lite_rd_if;
   import axi2iob_pkg::*;

   addr_t araddr;
   logic  arvalid;
   logic  arready;
   data_t rdata;
   logic  rvalid;
   logic  rready;

   modport manager (
      output araddr, arvalid, rready,
      input  arready, rdata, rvalid
   );

   modport subordinate (
      input  araddr, arvalid, rready,
      output arready, rdata, rvalid
   );

endinterface

// File: logic/lite_wr_if.sv
// Single-beat write channel from the write burst sequencer to the bus bridge.
// One address, one data word and one response per beat.
`timescale 1ns/1ps

interface lite_wr_if;
   import axi2iob_pkg::*;

   addr_t awaddr;
   logic  awvalid;
   logic  awready;
   data_t wdata;
   strb_t wstrb;
   logic  wvalid;
   logic  wready;
   logic  bvalid;
   logic  bready;

   modport manager (
      output awaddr, awvalid, wdata, wstrb, wvalid, bready,
      input  awready, wready, bvalid
   );

   modport subordinate (
      input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
      output awready, wready, bvalid
   );

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the adapter testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f axi2iob_top.f --top-module axi2iob_tb -o axi2iob_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/axi2iob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

// File: sim/axi2iob_tb.sv
// Testbench for the AXI4 to IOb adapter. Applies a table of write and read
// bursts against the IOb memory model and checks responses against a reference.
`timescale 1ns/1ps

module axi2iob_tb;
   import axi2iob_pkg::*;

   localparam int WORDS      = 256;
   localparam int N_TESTS    = 11;
   localparam int BEAT_LIMIT = 40;

   typedef struct packed {
      logic  wr;
      id_t   id;
      addr_t addr;
      len_t  len;
      data_t base;
      strb_t strb;
   } test_t;

   logic  clk_i     = 1'b0;
   logic  arst_i    = 1'b1;
   id_t   awid_i    = '0;
   addr_t awaddr_i  = '0;
   len_t  awlen_i   = '0;
   size_t awsize_i  = 3'd2;
   logic  awvalid_i = 1'b0;
   data_t wdata_i   = '0;
   strb_t wstrb_i   = '0;
   logic  wlast_i   = 1'b0;
   logic  wvalid_i  = 1'b0;
   logic  bready_i  = 1'b0;
   id_t   arid_i    = '0;
   addr_t araddr_i  = '0;
   len_t  arlen_i   = '0;
   size_t arsize_i  = 3'd2;
   logic  arvalid_i = 1'b0;
   logic  rready_i  = 1'b0;
   logic  awready_o, wready_o, bvalid_o, arready_o, rlast_o, rvalid_o;
   logic  iob_valid_o, iob_ready_i, iob_rvalid_i;
   id_t   bid_o, rid_o;
   data_t rdata_o, iob_wdata_o, iob_rdata_i;
   addr_t iob_addr_o;
   strb_t iob_wstrb_o;

   test_t tests [N_TESTS];
   data_t ref_mem [WORDS];
   id_t   b_ids [$];
   data_t r_data [$];
   id_t   r_ids [$];
   logic  r_lasts [$];
   int    errors       = 0;
   int    failed_tests = 0;
   int    total_beats  = 0;
   int    n_writes     = 0;
   int    b_total      = 0;
   logic  hold_b       = 1'b0;
   logic  hold_r       = 1'b0;
   id_t   held_bid, held_rid;
   data_t held_rdata;
   logic  held_rlast;

   always #50 clk_i = ~clk_i;

   axi2iob_top DUT (.*);

   tb_mem_model #(.WORDS(WORDS)) u_mem (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .iob_valid_i (iob_valid_o),
      .iob_addr_i  (iob_addr_o),
      .iob_wdata_i (iob_wdata_o),
      .iob_wstrb_i (iob_wstrb_o),
      .iob_ready_o (iob_ready_i),
      .iob_rvalid_o(iob_rvalid_i),
      .iob_rdata_o (iob_rdata_i)
   );

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      assert (got === exp) else begin
         $display("[ERROR] %s: expected %h, got %h", name, exp, got);
         errors++;
      end
   endtask

   function automatic data_t merge_bytes(data_t old, data_t wdata, strb_t strb);
      data_t res;
      res = old;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

   // size 2 bursts step four bytes per beat
   function automatic int word_index(addr_t addr, int k);
      return int'(((addr >> 2) + addr_t'(k)) % WORDS);
   endfunction

   function automatic data_t beat_data(data_t base, int k);
      return base ^ (data_t'(k) * 32'h0101_0101);
   endfunction

   task automatic load_tests();
      // dir, id, start address, len, data base, strobe
      tests[0]  = '{1'b1, 8'h11, 32'h0000_0010, 8'd0, 32'hDEAD_BEEF, 4'hF};
      tests[1]  = '{1'b0, 8'h21, 32'h0000_0010, 8'd0, 32'h0, 4'h0};
      tests[2]  = '{1'b1, 8'h12, 32'h0000_0040, 8'd3, 32'h1000_0000, 4'hF};
      tests[3]  = '{1'b0, 8'h22, 32'h0000_0040, 8'd3, 32'h0, 4'h0};
      tests[4]  = '{1'b1, 8'h13, 32'h0000_0044, 8'd1, 32'hAABB_CCDD, 4'b0101};
      tests[5]  = '{1'b1, 8'h14, 32'h0000_0048, 8'd0, 32'hFFFF_FFFF, 4'h0};
      tests[6]  = '{1'b0, 8'h23, 32'h0000_0040, 8'd3, 32'h0, 4'h0};
      tests[7]  = '{1'b1, 8'h15, 32'h0000_0080, 8'd7, 32'h5500_0000, 4'hF};
      tests[8]  = '{1'b1, 8'h16, 32'h0000_0084, 8'd2, 32'h0000_1234, 4'b1100};
      tests[9]  = '{1'b0, 8'h24, 32'h0000_0080, 8'd7, 32'h0, 4'h0};
      tests[10] = '{1'b0, 8'h25, 32'h0000_00C0, 8'd1, 32'h0, 4'h0};
      for (int t = 0; t < N_TESTS; t++) begin
         total_beats += int'(tests[t].len) + 1;
         if (tests[t].wr) n_writes++;
      end
   endtask

   task automatic run_write(input test_t t);
      int    idx;
      data_t wd;
      awid_i    = t.id;
      awaddr_i  = t.addr;
      awlen_i   = t.len;
      awvalid_i = 1'b1;
      while (!awready_o) @(negedge clk_i);
      @(negedge clk_i);
      awvalid_i = 1'b0;
      for (int k = 0; k <= int'(t.len); k++) begin
         wd       = beat_data(t.base, k);
         wdata_i  = wd;
         wstrb_i  = t.strb;
         wlast_i  = (k == int'(t.len));
         wvalid_i = 1'b1;
         idx = word_index(t.addr, k);
         ref_mem[idx] = merge_bytes(ref_mem[idx], wd, t.strb);
         while (!wready_o) @(negedge clk_i);
         @(negedge clk_i);
      end
      wvalid_i = 1'b0;
      wlast_i  = 1'b0;
      while (b_ids.size() == 0) @(negedge clk_i);
      check_value("bid_o", t.id, b_ids.pop_front());
   endtask

   task automatic run_read(input test_t t);
      int idx;
      arid_i    = t.id;
      araddr_i  = t.addr;
      arlen_i   = t.len;
      arvalid_i = 1'b1;
      while (!arready_o) @(negedge clk_i);
      @(negedge clk_i);
      arvalid_i = 1'b0;
      for (int k = 0; k <= int'(t.len); k++) begin
         idx = word_index(t.addr, k);
         while (r_data.size() == 0) @(negedge clk_i);
         check_value("rdata_o", ref_mem[idx], r_data.pop_front());
         check_value("rid_o", t.id, r_ids.pop_front());
         check_value("rlast_o", k == int'(t.len), r_lasts.pop_front());
      end
   endtask

   // random back-pressure, hold checks and beat capture on the response side
   always @(negedge clk_i) begin
      if (hold_b) begin
         check_value("bvalid_o", 1, bvalid_o);
         check_value("bid_o", held_bid, bid_o);
      end
      if (hold_r) begin
         check_value("rvalid_o", 1, rvalid_o);
         check_value("rid_o", held_rid, rid_o);
         check_value("rdata_o", held_rdata, rdata_o);
         check_value("rlast_o", held_rlast, rlast_o);
      end
      bready_i = !arst_i && ($urandom % 3 != 0);
      rready_i = !arst_i && ($urandom % 3 != 0);
      if (bvalid_o && bready_i) begin
         b_ids.push_back(bid_o);
         b_total++;
      end
      if (rvalid_o && rready_i) begin
         r_data.push_back(rdata_o);
         r_ids.push_back(rid_o);
         r_lasts.push_back(rlast_o);
      end
      hold_b     = bvalid_o && !bready_i;
      hold_r     = rvalid_o && !rready_i;
      held_bid   = bid_o;
      held_rid   = rid_o;
      held_rdata = rdata_o;
      held_rlast = rlast_o;
   end

   initial begin
      void'($urandom(22611));
      load_tests();
      for (int i = 0; i < WORDS; i++) begin
         ref_mem[i] = 32'hC3C3_0000 ^ data_t'(i << 2);
      end
      repeat (2) @(negedge clk_i);
      arst_i = 1'b0;
      for (int t = 0; t < N_TESTS; t++) begin
         int err_before;
         err_before = errors;
         if (tests[t].wr) begin
            run_write(tests[t]);
         end else begin
            run_read(tests[t]);
         end
         if (errors != err_before) failed_tests++;
         $display("test %0d %s id %h addr %h len %0d: %s", t,
                  tests[t].wr ? "write" : "read", tests[t].id, tests[t].addr,
                  tests[t].len, errors == err_before ? "ok" : "FAILED");
      end
      check_value("bvalid_o count", n_writes, b_total);
      check_value("rvalid_o beats left over", 0, r_data.size());
      $display("tests run %0d, tests failed %0d, check errors %0d",
               N_TESTS, failed_tests, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // bound scales with the number of beats in the table
   initial begin
      wait (total_beats != 0);
      repeat (total_beats * BEAT_LIMIT + 20 * N_TESTS) @(negedge clk_i);
      $display("timeout: the bursts did not finish in time, the run is stopped");
      $display("Errors found");
      $finish;
   end

endmodule

// File: sim/tb_mem_model.sv
// IOb memory model for the adapter testbench. Word array with byte-strobe
// writes, random ready stalls and read data one cycle after the read is taken.
`timescale 1ns/1ps

module tb_mem_model #(
   parameter int WORDS = 256
) (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic               iob_valid_i,
   input  axi2iob_pkg::addr_t iob_addr_i,
   input  axi2iob_pkg::data_t iob_wdata_i,
   input  axi2iob_pkg::strb_t iob_wstrb_i,
   output logic               iob_ready_o,
   output logic               iob_rvalid_o,
   output axi2iob_pkg::data_t iob_rdata_o
);
   import axi2iob_pkg::*;

   data_t mem [WORDS];
   data_t rd_word;
   logic  rd_pending;
   int    idx;

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hC3C3_0000 ^ data_t'(i << 2);
      end
      iob_ready_o  = 1'b0;
      iob_rvalid_o = 1'b0;
      iob_rdata_o  = '0;
      rd_pending   = 1'b0;
      forever begin
         @(negedge clk_i);
         // answer the read taken at the last rising edge
         iob_rvalid_o = rd_pending;
         if (rd_pending) begin
            iob_rdata_o = rd_word;
         end
         rd_pending  = 1'b0;
         iob_ready_o = !arst_i && ($urandom % 4 != 0);
         if (iob_valid_i && iob_ready_o) begin
            idx = int'((iob_addr_i >> 2) % WORDS);
            if (iob_wstrb_i != '0) begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (iob_wstrb_i[b]) mem[idx][8*b +: 8] = iob_wdata_i[8*b +: 8];
               end
            end else begin
               rd_word    = mem[idx];
               rd_pending = 1'b1;
            end
         end
      end
   end

endmodule
